// ==== src/radio_pkg.sv ====
`default_nettype none

package radio_pkg;

   // ----------------------------
   // slot geometry
   // ----------------------------
   localparam int NUM_DBOARDS  = 2;                 // daughterboard slots
   localparam int CHANS_PER_DB = 2;                 // channels per slot
   localparam int FE_LANES     = 2 * CHANS_PER_DB;  // fe lanes, rx channels first then tx
   localparam int LED_W        = 3;                 // ordered rx, txrx_tx, txrx_rx

   // ----------------------------
   // settings and readback map
   // ----------------------------
   localparam logic [7:0] SR_DB_BASE        = 8'd160;               // +0 gpio out, +1 ddr, +2 misc
   localparam logic [7:0] RB_DB_BASE        = 8'd16;                // +0 gpio in, +1 misc in
   localparam logic [7:0] SR_FE_CHAN_OFFSET = 8'd16;                // stride between channels
   localparam logic [7:0] SR_TX_FE_BASE     = SR_DB_BASE + 8'd48;   // 208
   localparam logic [7:0] SR_RX_FE_BASE     = SR_DB_BASE + 8'd64;   // 224

   // settings write, single cycle strobe, no ack
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // readback request, answered two edges later
   typedef struct packed {
      logic       stb;
      logic [7:0] addr;
   } rb_bus_t;

   // complex sample, i in the upper half
   typedef struct packed {
      logic [15:0] i;
      logic [15:0] q;
   } iq_t;

   // buses move the raw word, fe datapath works on i and q
   typedef union packed {
      logic [31:0] word;
      iq_t         iq;
   } sample_u;

endpackage

`default_nettype wire

// ==== src/db_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module db_control (
   input  wire logic                         radio_clk,
   input  wire logic                         i_arst_n,
   // settings and readback
   input  wire radio_pkg::set_bus_t          i_set,
   input  wire radio_pkg::rb_bus_t           i_rb,
   output logic                              o_rb_stb,
   output logic [63:0]                       o_rb_data,
   // slot atr levels
   input  wire logic                         i_run_rx,
   input  wire logic                         i_run_tx,
   // daughterboard io
   input  wire logic [31:0]                  i_db_gpio_in,
   output logic [31:0]                       o_db_gpio_out,
   output logic [31:0]                       o_db_gpio_ddr,
   input  wire logic [31:0]                  i_misc_in,
   output logic [31:0]                       o_misc_out,
   output logic [radio_pkg::LED_W-1:0]       o_leds
);

   logic [31:0] gpio_in_q;   // pin sample, one stage
   logic [31:0] misc_in_q;
   logic        rb_req_q;    // readback request, first stage
   logic [7:0]  rb_addr_q;
   logic [31:0] rb_mux;      // selected readback word

   // ----------------------------
   // settings registers
   // ----------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_misc_out    <= '0;
      end else if (i_set.stb) begin   // other addresses belong to fe_correct
         case (i_set.addr)
            radio_pkg::SR_DB_BASE:         o_db_gpio_out <= i_set.data;
            radio_pkg::SR_DB_BASE + 8'd1:  o_db_gpio_ddr <= i_set.data;  // 1 = output
            radio_pkg::SR_DB_BASE + 8'd2:  o_misc_out    <= i_set.data;
            default: ;
         endcase
      end
   end

   // input sampling, readback sees these and never the raw pins
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         gpio_in_q <= '0;
         misc_in_q <= '0;
      end else begin
         gpio_in_q <= i_db_gpio_in;
         misc_in_q <= i_misc_in;
      end
   end

   // ----------------------------
   // readback, two stages
   // ----------------------------
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rb_req_q  <= 1'b0;
         rb_addr_q <= '0;
      end else begin
         rb_req_q  <= i_rb.stb;
         rb_addr_q <= i_rb.addr;   // held with the request
      end
   end

   always_comb begin
      case (rb_addr_q)
         radio_pkg::RB_DB_BASE:         rb_mux = gpio_in_q;
         radio_pkg::RB_DB_BASE + 8'd1:  rb_mux = misc_in_q;
         default:                       rb_mux = '0;   // unmapped reads as zero
      endcase
   end

   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb  <= rb_req_q;   // one pulse per request
         o_rb_data <= {32'd0, rb_mux};
      end
   end

   // atr leds
   // txrx_rx only lights while receiving without transmit
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_leds <= '0;
      else
         o_leds <= {i_run_rx, i_run_tx, i_run_rx & ~i_run_tx};
   end

endmodule

`default_nettype wire

// ==== src/fe_correct.sv ====
`timescale 1ns/1ns
`default_nettype none

module fe_correct (
   input  wire logic                             radio_clk,
   input  wire logic                             i_arst_n,
   input  wire radio_pkg::set_bus_t              i_set,
   // rx, one strobe shared by the duplicated adc word
   input  wire radio_pkg::sample_u               i_rx     [radio_pkg::CHANS_PER_DB],
   input  wire logic                             i_rx_stb,
   output wire radio_pkg::sample_u               o_rx     [radio_pkg::CHANS_PER_DB],
   output wire logic [radio_pkg::CHANS_PER_DB-1:0] o_rx_stb,
   // tx
   input  wire radio_pkg::sample_u               i_tx     [radio_pkg::CHANS_PER_DB],
   input  wire logic [radio_pkg::CHANS_PER_DB-1:0] i_tx_stb,
   output wire radio_pkg::sample_u               o_tx     [radio_pkg::CHANS_PER_DB],
   output wire logic [radio_pkg::CHANS_PER_DB-1:0] o_tx_stb
);

   // flat lane view, rx channels then tx channels
   radio_pkg::sample_u                lane_in  [radio_pkg::FE_LANES];
   radio_pkg::sample_u                lane_out [radio_pkg::FE_LANES];
   logic [radio_pkg::FE_LANES-1:0]    lane_stb;
   logic [radio_pkg::FE_LANES-1:0]    lane_stb_q;

   // ----------------------------
   // lane mapping
   // ----------------------------
   for (genvar ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++) begin : g_map
      assign lane_in[ch]                            = i_rx[ch];
      assign lane_in[radio_pkg::CHANS_PER_DB + ch]  = i_tx[ch];
      assign lane_stb[ch]                           = i_rx_stb;
      assign lane_stb[radio_pkg::CHANS_PER_DB + ch] = i_tx_stb[ch];

      assign o_rx[ch]     = lane_out[ch];
      assign o_rx_stb[ch] = lane_stb_q[ch];
      assign o_tx[ch]     = lane_out[radio_pkg::CHANS_PER_DB + ch];
      assign o_tx_stb[ch] = lane_stb_q[radio_pkg::CHANS_PER_DB + ch];
   end

   // ----------------------------
   // per lane offset and adder
   // ----------------------------
   for (genvar ln = 0; ln < radio_pkg::FE_LANES; ln++) begin : g_lane
      logic [7:0]         off_addr;   // settings address of this lane's offset
      radio_pkg::sample_u off_q;      // dc offset, i and q
      radio_pkg::sample_u sum_q;      // corrected sample
      logic               stb_q;

      // rx lanes sit above the tx block in the map
      assign off_addr = ((ln < radio_pkg::CHANS_PER_DB) ? radio_pkg::SR_RX_FE_BASE
                                                        : radio_pkg::SR_TX_FE_BASE)
                      + 8'(ln % radio_pkg::CHANS_PER_DB) * radio_pkg::SR_FE_CHAN_OFFSET;

      always_ff @(posedge radio_clk or negedge i_arst_n) begin
         if (!i_arst_n)
            off_q <= '0;   // no correction until written
         else if (i_set.stb && (i_set.addr == off_addr))
            off_q.word <= i_set.data;
      end

      // i and q wrap independently at 16 bits
      always_ff @(posedge radio_clk or negedge i_arst_n) begin
         if (!i_arst_n) begin
            sum_q <= '0;
         end else if (lane_stb[ln]) begin
            sum_q.iq.i <= lane_in[ln].iq.i + off_q.iq.i;
            sum_q.iq.q <= lane_in[ln].iq.q + off_q.iq.q;
         end
      end

      always_ff @(posedge radio_clk or negedge i_arst_n) begin
         if (!i_arst_n)
            stb_q <= 1'b0;
         else
            stb_q <= lane_stb[ln];   // lines up with sum_q
      end

      assign lane_out[ln]   = sum_q;
      assign lane_stb_q[ln] = stb_q;
   end

endmodule

`default_nettype wire

// ==== src/radio_slot.sv ====
`timescale 1ns/1ns
`default_nettype none

module radio_slot (
   input  wire logic                               radio_clk,
   input  wire logic                               i_arst_n,
   input  wire radio_pkg::set_bus_t                i_set,
   input  wire radio_pkg::rb_bus_t                 i_rb,
   output wire logic                               o_rb_stb,
   output wire logic [63:0]                        o_rb_data,
   input  wire radio_pkg::sample_u                 i_rx,        // adc word
   input  wire logic                               i_rx_stb,
   input  wire radio_pkg::sample_u                 i_host_tx    [radio_pkg::CHANS_PER_DB],
   input  wire logic [radio_pkg::CHANS_PER_DB-1:0] i_tx_stb,
   input  wire logic [radio_pkg::CHANS_PER_DB-1:0] i_rx_running,
   input  wire logic [radio_pkg::CHANS_PER_DB-1:0] i_tx_running,
   input  wire radio_pkg::sample_u                 i_bb_tx,     // baseband engine
   input  wire radio_pkg::sample_u                 i_bb_rx,
   output wire radio_pkg::sample_u                 o_host_rx    [radio_pkg::CHANS_PER_DB],
   output wire logic [radio_pkg::CHANS_PER_DB-1:0] o_rx_stb,
   output wire radio_pkg::sample_u                 o_tx,        // dac word
   output wire logic                               o_tx_stb,
   input  wire logic [31:0]                        i_db_gpio_in,
   output wire logic [31:0]                        o_db_gpio_out,
   output wire logic [31:0]                        o_db_gpio_ddr,
   input  wire logic [31:0]                        i_misc_in,
   output wire logic [31:0]                        o_misc_out,
   output wire logic [radio_pkg::LED_W-1:0]        o_leds
);

   radio_pkg::sample_u                 rx_dup [radio_pkg::CHANS_PER_DB];   // same adc word
   radio_pkg::sample_u                 tx_sel [radio_pkg::CHANS_PER_DB];   // host or baseband
   radio_pkg::sample_u                 rx_fe  [radio_pkg::CHANS_PER_DB];
   radio_pkg::sample_u                 tx_fe  [radio_pkg::CHANS_PER_DB];
   logic [radio_pkg::CHANS_PER_DB-1:0] tx_fe_stb;

   // ----------------------------
   // baseband substitution
   // ----------------------------
   // channel 0 running bits steer both lanes
   for (genvar ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++) begin : g_chan
      assign rx_dup[ch]    = i_rx;
      assign tx_sel[ch]    = i_tx_running[0] ? i_bb_tx : i_host_tx[ch];
      assign o_host_rx[ch] = i_rx_running[0] ? i_bb_rx : rx_fe[ch];   // after correction
   end

   assign o_tx     = tx_fe[0];       // only channel 0 reaches the dac
   assign o_tx_stb = tx_fe_stb[0];

   db_control u_db_control (
      .radio_clk     (radio_clk),
      .i_arst_n      (i_arst_n),
      .i_set         (i_set),
      .i_rb          (i_rb),
      .o_rb_stb      (o_rb_stb),
      .o_rb_data     (o_rb_data),
      .i_run_rx      (|i_rx_running),   // slot atr is any channel
      .i_run_tx      (|i_tx_running),
      .i_db_gpio_in  (i_db_gpio_in),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .i_misc_in     (i_misc_in),
      .o_misc_out    (o_misc_out),
      .o_leds        (o_leds)
   );

   fe_correct u_fe_correct (
      .radio_clk (radio_clk),
      .i_arst_n  (i_arst_n),
      .i_set     (i_set),
      .i_rx      (rx_dup),
      .i_rx_stb  (i_rx_stb),
      .o_rx      (rx_fe),
      .o_rx_stb  (o_rx_stb),
      .i_tx      (tx_sel),
      .i_tx_stb  (i_tx_stb),
      .o_tx      (tx_fe),
      .o_tx_stb  (tx_fe_stb)
   );

endmodule

`default_nettype wire

// ==== src/radio_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module radio_core (
   input  wire logic                               radio_clk,
   input  wire logic                               i_arst_n,
   // per slot settings and readback
   input  wire radio_pkg::set_bus_t                i_set         [radio_pkg::NUM_DBOARDS],
   input  wire radio_pkg::rb_bus_t                 i_rb          [radio_pkg::NUM_DBOARDS],
   output wire logic [radio_pkg::NUM_DBOARDS-1:0]  o_rb_stb,
   output wire logic [63:0]                        o_rb_data     [radio_pkg::NUM_DBOARDS],
   // samples
   input  wire radio_pkg::sample_u                 i_rx          [radio_pkg::NUM_DBOARDS],
   input  wire logic [radio_pkg::NUM_DBOARDS-1:0]  i_rx_stb,
   input  wire radio_pkg::sample_u                 i_host_tx
                                        [radio_pkg::NUM_DBOARDS][radio_pkg::CHANS_PER_DB],
   input  wire logic [radio_pkg::CHANS_PER_DB-1:0] i_tx_stb      [radio_pkg::NUM_DBOARDS],
   input  wire logic [radio_pkg::CHANS_PER_DB-1:0] i_rx_running  [radio_pkg::NUM_DBOARDS],
   input  wire logic [radio_pkg::CHANS_PER_DB-1:0] i_tx_running  [radio_pkg::NUM_DBOARDS],
   input  wire radio_pkg::sample_u                 i_bb_tx       [radio_pkg::NUM_DBOARDS],
   input  wire radio_pkg::sample_u                 i_bb_rx       [radio_pkg::NUM_DBOARDS],
   output wire radio_pkg::sample_u                 o_host_rx
                                        [radio_pkg::NUM_DBOARDS][radio_pkg::CHANS_PER_DB],
   output wire logic [radio_pkg::CHANS_PER_DB-1:0] o_rx_stb      [radio_pkg::NUM_DBOARDS],
   output wire radio_pkg::sample_u                 o_tx          [radio_pkg::NUM_DBOARDS],
   output wire logic [radio_pkg::NUM_DBOARDS-1:0]  o_tx_stb,
   // daughterboard io
   input  wire logic [31:0]                        i_db_gpio_in  [radio_pkg::NUM_DBOARDS],
   output wire logic [31:0]                        o_db_gpio_out [radio_pkg::NUM_DBOARDS],
   output wire logic [31:0]                        o_db_gpio_ddr [radio_pkg::NUM_DBOARDS],
   input  wire logic [31:0]                        i_misc_in     [radio_pkg::NUM_DBOARDS],
   output wire logic [31:0]                        o_misc_out    [radio_pkg::NUM_DBOARDS],
   output wire logic [radio_pkg::LED_W-1:0]        o_leds        [radio_pkg::NUM_DBOARDS]
);

   // ----------------------------
   // one slot per daughterboard
   // ----------------------------
   for (genvar s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin : g_slot
      radio_slot u_slot (
         .radio_clk     (radio_clk),
         .i_arst_n      (i_arst_n),
         .i_set         (i_set[s]),
         .i_rb          (i_rb[s]),
         .o_rb_stb      (o_rb_stb[s]),
         .o_rb_data     (o_rb_data[s]),
         .i_rx          (i_rx[s]),
         .i_rx_stb      (i_rx_stb[s]),
         .i_host_tx     (i_host_tx[s]),
         .i_tx_stb      (i_tx_stb[s]),
         .i_rx_running  (i_rx_running[s]),   // slot local, no cross-slot steering
         .i_tx_running  (i_tx_running[s]),
         .i_bb_tx       (i_bb_tx[s]),
         .i_bb_rx       (i_bb_rx[s]),
         .o_host_rx     (o_host_rx[s]),
         .o_rx_stb      (o_rx_stb[s]),
         .o_tx          (o_tx[s]),
         .o_tx_stb      (o_tx_stb[s]),
         .i_db_gpio_in  (i_db_gpio_in[s]),
         .o_db_gpio_out (o_db_gpio_out[s]),
         .o_db_gpio_ddr (o_db_gpio_ddr[s]),
         .i_misc_in     (i_misc_in[s]),
         .o_misc_out    (o_misc_out[s]),
         .o_leds        (o_leds[s])
      );
   end

endmodule

`default_nettype wire

// ==== sim/radio_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module radio_core_tb #(
   parameter int SEED      = 66612,
   parameter int NUM_TESTS = 6
);

   logic radio_clk = 1'b0;
   logic arst_n;
   // dut inputs
   radio_pkg::set_bus_t set [radio_pkg::NUM_DBOARDS];
   radio_pkg::rb_bus_t  rb  [radio_pkg::NUM_DBOARDS];
   radio_pkg::sample_u  rx [radio_pkg::NUM_DBOARDS];
   radio_pkg::sample_u  bb_tx [radio_pkg::NUM_DBOARDS];
   radio_pkg::sample_u  bb_rx [radio_pkg::NUM_DBOARDS];
   radio_pkg::sample_u  host_tx [radio_pkg::NUM_DBOARDS][radio_pkg::CHANS_PER_DB];
   logic [radio_pkg::NUM_DBOARDS-1:0]  rx_stb;
   logic [radio_pkg::CHANS_PER_DB-1:0] tx_stb [radio_pkg::NUM_DBOARDS];
   logic [radio_pkg::CHANS_PER_DB-1:0] rx_running [radio_pkg::NUM_DBOARDS];
   logic [radio_pkg::CHANS_PER_DB-1:0] tx_running [radio_pkg::NUM_DBOARDS];
   logic [31:0] gpio_in [radio_pkg::NUM_DBOARDS];
   logic [31:0] misc_in [radio_pkg::NUM_DBOARDS];
   // dut outputs
   logic [radio_pkg::NUM_DBOARDS-1:0]  o_rb_stb;
   logic [radio_pkg::NUM_DBOARDS-1:0]  o_tx_stb;
   logic [63:0] o_rb_data [radio_pkg::NUM_DBOARDS];
   radio_pkg::sample_u  o_host_rx [radio_pkg::NUM_DBOARDS][radio_pkg::CHANS_PER_DB];
   radio_pkg::sample_u  o_tx [radio_pkg::NUM_DBOARDS];
   logic [radio_pkg::CHANS_PER_DB-1:0] o_rx_stb [radio_pkg::NUM_DBOARDS];
   logic [31:0] gpio_out [radio_pkg::NUM_DBOARDS];
   logic [31:0] gpio_ddr [radio_pkg::NUM_DBOARDS];
   logic [31:0] misc_out [radio_pkg::NUM_DBOARDS];
   logic [radio_pkg::LED_W-1:0] leds [radio_pkg::NUM_DBOARDS];
   // reference model state
   logic [31:0] exp_gpio_out [radio_pkg::NUM_DBOARDS];
   logic [31:0] exp_ddr [radio_pkg::NUM_DBOARDS];
   logic [31:0] exp_misc [radio_pkg::NUM_DBOARDS];
   logic [31:0] rb_d1 [radio_pkg::NUM_DBOARDS];
   logic [31:0] rb_d2 [radio_pkg::NUM_DBOARDS];
   logic [radio_pkg::NUM_DBOARDS-1:0] rb_v1;
   logic [radio_pkg::NUM_DBOARDS-1:0] rb_v2;
   logic [radio_pkg::NUM_DBOARDS-1:0] rx_seen;
   logic [radio_pkg::NUM_DBOARDS-1:0] tx_seen;
   logic [radio_pkg::LED_W-1:0] exp_leds [radio_pkg::NUM_DBOARDS];
   radio_pkg::sample_u rx_off [radio_pkg::NUM_DBOARDS][radio_pkg::CHANS_PER_DB];
   radio_pkg::sample_u tx_off [radio_pkg::NUM_DBOARDS][radio_pkg::CHANS_PER_DB];
   radio_pkg::sample_u exp_rx [radio_pkg::NUM_DBOARDS][radio_pkg::CHANS_PER_DB];
   radio_pkg::sample_u exp_tx [radio_pkg::NUM_DBOARDS];
   int strobe_errors = 0;
   int data_errors   = 0;
   int reset_errors  = 0;

   always #5 radio_clk = ~radio_clk;   // 10 ns period

   radio_core UUT (
      .radio_clk     (radio_clk),
      .i_arst_n      (arst_n),
      .i_set         (set),
      .i_rb          (rb),
      .o_rb_stb      (o_rb_stb),
      .o_rb_data     (o_rb_data),
      .i_rx          (rx),
      .i_rx_stb      (rx_stb),
      .i_host_tx     (host_tx),
      .i_tx_stb      (tx_stb),
      .i_rx_running  (rx_running),
      .i_tx_running  (tx_running),
      .i_bb_tx       (bb_tx),
      .i_bb_rx       (bb_rx),
      .o_host_rx     (o_host_rx),
      .o_rx_stb      (o_rx_stb),
      .o_tx          (o_tx),
      .o_tx_stb      (o_tx_stb),
      .i_db_gpio_in  (gpio_in),
      .o_db_gpio_out (gpio_out),
      .o_db_gpio_ddr (gpio_ddr),
      .i_misc_in     (misc_in),
      .o_misc_out    (misc_out),
      .o_leds        (leds)
   );

   // i and q each wrap at 16 bits
   function automatic radio_pkg::sample_u add_offset(input radio_pkg::sample_u smp,
                                                     input radio_pkg::sample_u off);
      radio_pkg::sample_u r;
      r.iq.i = smp.iq.i + off.iq.i;
      r.iq.q = smp.iq.q + off.iq.q;
      return r;
   endfunction

   function automatic logic [7:0] fe_addr(input logic [7:0] base, input int ch);
      return base + 8'(ch) * radio_pkg::SR_FE_CHAN_OFFSET;
   endfunction

   function automatic logic [31:0] rb_expect(input logic [7:0] addr, input logic [31:0] gin,
                                             input logic [31:0] min);
      if (addr == radio_pkg::RB_DB_BASE) return gin;
      if (addr == radio_pkg::RB_DB_BASE + 8'd1) return min;
      return 32'd0;   // unmapped
   endfunction

   // ------------------------------
   // reference model, posedge
   // ------------------------------
   always @(posedge radio_clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin
            exp_gpio_out[s] <= '0;
            exp_ddr[s]      <= '0;
            exp_misc[s]     <= '0;
            exp_leds[s]     <= '0;
            for (int ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++) begin
               rx_off[s][ch] <= '0;
               tx_off[s][ch] <= '0;
            end
         end
         rx_seen <= '0;   // corrected samples are unknown until the first strobe
         tx_seen <= '0;
         rb_v1   <= '0;
         rb_v2   <= '0;
      end else begin
         for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin
            if (set[s].stb) begin
               if (set[s].addr == radio_pkg::SR_DB_BASE) exp_gpio_out[s] <= set[s].data;
               if (set[s].addr == radio_pkg::SR_DB_BASE + 8'd1) exp_ddr[s] <= set[s].data;
               if (set[s].addr == radio_pkg::SR_DB_BASE + 8'd2) exp_misc[s] <= set[s].data;
               for (int ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++) begin
                  if (set[s].addr == fe_addr(radio_pkg::SR_RX_FE_BASE, ch))
                     rx_off[s][ch].word <= set[s].data;
                  if (set[s].addr == fe_addr(radio_pkg::SR_TX_FE_BASE, ch))
                     tx_off[s][ch].word <= set[s].data;
               end
            end
            exp_leds[s] <= {|rx_running[s], |tx_running[s],
                            (|rx_running[s]) & ~(|tx_running[s])};
            rb_v1[s] <= rb[s].stb;
            rb_d1[s] <= rb_expect(rb[s].addr, gpio_in[s], misc_in[s]);
            rb_v2[s] <= rb_v1[s];   // answer one edge after the request stage
            rb_d2[s] <= rb_d1[s];
            if (rx_stb[s]) begin
               rx_seen[s] <= 1'b1;
               for (int ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++)
                  exp_rx[s][ch] <= add_offset(rx[s], rx_off[s][ch]);   // adc word on both
            end
            if (tx_stb[s][0]) begin
               tx_seen[s] <= 1'b1;
               exp_tx[s]  <= add_offset(tx_running[s][0] ? bb_tx[s] : host_tx[s][0],
                                        tx_off[s][0]);
            end
         end
      end
   end

   // ------------------------------
   // checks, negedge
   // ------------------------------
   for (genvar s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin : g_stb_chk
      assert property (@(negedge radio_clk) disable iff (!arst_n)
            o_rb_stb[s] == $past(rb[s].stb, 2))
         else begin
            strobe_errors++;
            $display("Error %0t: slot %0d readback strobe", $time, s);
         end
      assert property (@(negedge radio_clk) disable iff (!arst_n)
            o_rx_stb[s] == {radio_pkg::CHANS_PER_DB{$past(rx_stb[s])}})
         else begin
            strobe_errors++;
            $display("Error %0t: slot %0d rx strobe", $time, s);
         end
      assert property (@(negedge radio_clk) disable iff (!arst_n)
            o_tx_stb[s] == $past(tx_stb[s][0]))
         else begin
            strobe_errors++;
            $display("Error %0t: slot %0d tx strobe", $time, s);
         end
   end

   always @(negedge radio_clk) begin
      if (arst_n) begin
         for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin
            assert (gpio_out[s] == exp_gpio_out[s] && gpio_ddr[s] == exp_ddr[s]
                    && misc_out[s] == exp_misc[s])
               else begin
                  data_errors++;
                  $display("Error %0t: slot %0d settings out %h %h %h, expected %h %h %h",
                           $time, s, gpio_out[s], gpio_ddr[s], misc_out[s],
                           exp_gpio_out[s], exp_ddr[s], exp_misc[s]);
               end
            assert (leds[s] == exp_leds[s])
               else begin
                  data_errors++;
                  $display("Error %0t: slot %0d leds %b, expected %b",
                           $time, s, leds[s], exp_leds[s]);
               end
            if (rb_v2[s]) begin
               assert (o_rb_data[s] == {32'd0, rb_d2[s]})
                  else begin
                     data_errors++;
                     $display("Error %0t: slot %0d readback %h, expected %h",
                              $time, s, o_rb_data[s], rb_d2[s]);
                  end
            end
            for (int ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++) begin
               if (rx_running[s][0]) begin   // baseband takes over host rx
                  assert (o_host_rx[s][ch] == bb_rx[s])
                     else begin
                        data_errors++;
                        $display("Error %0t: slot %0d ch %0d bb rx %h",
                                 $time, s, ch, o_host_rx[s][ch]);
                     end
               end else if (rx_seen[s]) begin
                  assert (o_host_rx[s][ch] == exp_rx[s][ch])
                     else begin
                        data_errors++;
                        $display("Error %0t: slot %0d ch %0d rx %h, expected %h",
                                 $time, s, ch, o_host_rx[s][ch], exp_rx[s][ch]);
                     end
               end
            end
            if (tx_seen[s]) begin
               assert (o_tx[s] == exp_tx[s])
                  else begin
                     data_errors++;
                     $display("Error %0t: slot %0d tx %h, expected %h",
                              $time, s, o_tx[s], exp_tx[s]);
                  end
            end
         end
      end
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   task automatic next_cycle(input int n);   // ends 1 ns after an edge
      repeat (n) @(posedge radio_clk);
      #1;
   endtask

   task automatic write_setting(input int s, input logic [7:0] addr, input logic [31:0] data);
      set[s].stb  = 1'b1;
      set[s].addr = addr;
      set[s].data = data;
      next_cycle(1);
      set[s].stb  = 1'b0;
   endtask

   task automatic read_back(input int s, input logic [7:0] addr);
      rb[s].stb  = 1'b1;
      rb[s].addr = addr;
      next_cycle(1);
      rb[s].stb  = 1'b0;
      next_cycle(3);   // let the answer come out
   endtask

   task automatic stream_samples(input int n);
      logic [31:0] r;
      repeat (n) begin
         for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin
            r                  = $urandom();
            rx[s].word         = $urandom();
            bb_rx[s].word      = $urandom();
            bb_tx[s].word      = $urandom();
            host_tx[s][0].word = $urandom();
            host_tx[s][1].word = $urandom();
            rx_stb[s]          = r[0];     // random gaps in the stream
            tx_stb[s]          = r[2:1];
         end
         next_cycle(1);
      end
      rx_stb = '0;
      for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++) tx_stb[s] = '0;
   endtask

   initial begin
      void'($urandom(SEED));
      arst_n   = 1'b0;
      rx_stb   = '0;
      for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin
         set[s]        = '0;
         rb[s]         = '0;
         rx[s]         = '0;
         bb_tx[s]      = '0;
         bb_rx[s]      = '0;
         host_tx[s][0] = '0;
         host_tx[s][1] = '0;
         tx_stb[s]     = '0;
         rx_running[s] = '0;
         tx_running[s] = '0;
         gpio_in[s]    = '0;
         misc_in[s]    = '0;
      end
      repeat (8) @(posedge radio_clk);
      #1 arst_n = 1'b1;
      // reset state
      @(negedge radio_clk);
      for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++)
         assert (gpio_out[s] == 0 && gpio_ddr[s] == 0 && misc_out[s] == 0 && leds[s] == 0
                 && o_rb_stb[s] == 0 && o_rx_stb[s] == 0 && o_tx_stb[s] == 0)
            else begin
               reset_errors++;
               $display("Error %0t: slot %0d not clear after reset", $time, s);
            end
      next_cycle(1);
      // settings and readback
      for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++) begin
         write_setting(s, radio_pkg::SR_DB_BASE, $urandom());
         write_setting(s, radio_pkg::SR_DB_BASE + 8'd1, $urandom());
         write_setting(s, radio_pkg::SR_DB_BASE + 8'd2, $urandom());
         gpio_in[s] = $urandom();
         misc_in[s] = $urandom();
         next_cycle(2);
         read_back(s, radio_pkg::RB_DB_BASE);
         read_back(s, radio_pkg::RB_DB_BASE + 8'd1);
         read_back(s, radio_pkg::RB_DB_BASE + 8'd7);   // nothing mapped here
      end
      // rx then tx correction
      for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++)
         for (int ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++)
            write_setting(s, fe_addr(radio_pkg::SR_RX_FE_BASE, ch), $urandom());
      stream_samples(40);
      for (int s = 0; s < radio_pkg::NUM_DBOARDS; s++)
         for (int ch = 0; ch < radio_pkg::CHANS_PER_DB; ch++)
            write_setting(s, fe_addr(radio_pkg::SR_TX_FE_BASE, ch), $urandom());
      stream_samples(40);
      // baseband on slot 0 only
      rx_running[0] = 2'b01;
      tx_running[0] = 2'b01;
      stream_samples(40);
      rx_running[0] = '0;
      tx_running[0] = '0;
      // atr leds, every combination on slot 0
      for (int c = 0; c < 16; c++) begin
         rx_running[0] = 2'(c);
         tx_running[0] = 2'(c >> 2);
         rx_running[1] = 2'($urandom());
         tx_running[1] = 2'($urandom());
         next_cycle(2);
      end
      next_cycle(4);
      $display("reset errors %0d, strobe errors %0d, data errors %0d",
               reset_errors, strobe_errors, data_errors);
      if (reset_errors + strobe_errors + data_errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // watchdog, sized from the test count
   initial begin
      #((NUM_TESTS * 200 + 100) * 10);
      $display("Timeout: run did not finish within %0d cycles", NUM_TESTS * 200 + 100);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== radio_core.f ====
src/radio_pkg.sv
src/db_control.sv
src/fe_correct.sv
src/radio_slot.sv
src/radio_core.sv
sim/radio_core_tb.sv

// ==== Makefile ====
# Verilator build for the radio core testbench

VERILATOR ?= verilator
TOP       ?= radio_core_tb
RTL_TOP   ?= radio_core
SEED      ?= 66612
LOG       ?= sim.log
FILELIST  ?= radio_core.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --assert --timing -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
